// File: source/board_pkg.sv
package board_pkg;

    typedef logic [ 7:0] key_t;    // Panel key levels, key 0 in bit 0
    typedef logic [ 7:0] led_t;
    typedef logic [ 7:0] seg_t;    // abcdefgh, segment a in bit 7, h is the point
    typedef logic [31:0] count_t;

    localparam int w_digit         = 8;
    localparam int clk_mhz_default = 100;
    localparam int tick_hz_default = 1;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Standard hex font, the decimal point stays dark

    function automatic seg_t hex_to_segments(input logic [3:0] nibble);
        seg_t segments;
        case (nibble)
            4'h0: segments = 8'hFC;
            4'h1: segments = 8'h60;
            4'h2: segments = 8'hDA;
            4'h3: segments = 8'hF2;
            4'h4: segments = 8'h66;
            4'h5: segments = 8'hB6;
            4'h6: segments = 8'hBE;
            4'h7: segments = 8'hE0;
            4'h8: segments = 8'hFE;
            4'h9: segments = 8'hF6;
            4'hA: segments = 8'hEE;
            4'hB: segments = 8'h3E;    // Lower case b
            4'hC: segments = 8'h9C;
            4'hD: segments = 8'h7A;    // Lower case d
            4'hE: segments = 8'h9E;
            default: segments = 8'h8E;
        endcase
        return segments;
    endfunction

endpackage

// File: source/tm1638_pkg.sv
package tm1638_pkg;

    typedef logic [7:0] byte_t;

    // Command bytes as the chip expects them
    localparam byte_t cmd_write_auto = 8'h40;    // Data write, auto address increment
    localparam byte_t cmd_read_keys  = 8'h42;
    localparam byte_t cmd_addr_base  = 8'hC0;    // Display RAM address 0
    localparam byte_t cmd_display_on = 8'h8F;    // Display on, full brightness

    typedef enum logic [1:0]
    {
        idle,
        strobe_setup,
        shift,
        gap
    } link_state_t;

    // Clock cycles in each half period of sio_clk
    localparam int sio_div_default = 4;

endpackage

// File: source/slow_tick_gen.sv
`timescale 1ns/10ps

module slow_tick_gen
# (
    parameter int fast_clk_mhz = board_pkg::clk_mhz_default,
    parameter int tick_hz      = board_pkg::tick_hz_default
)
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int period = fast_clk_mhz * 1000000 / tick_hz;
    localparam int w_cnt  = $clog2(period);

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else
        begin
            tick <= cnt == w_cnt'(period - 1);    // One strobe per wrap
            cnt  <= (cnt == w_cnt'(period - 1)) ? '0 : cnt + 1'b1;
        end
    end

    a_tick_single : assert property (@(posedge clk) disable iff (rst) tick |=> !tick);

endmodule

// File: source/lab_counter.sv
`timescale 1ns/10ps

module lab_counter
(
    input  logic            clk,
    input  logic            rst,
    input  logic            tick,
    input  board_pkg::key_t key,

    output board_pkg::seg_t seg0,
    output board_pkg::seg_t seg1,
    output board_pkg::seg_t seg2,
    output board_pkg::seg_t seg3,
    output board_pkg::seg_t seg4,
    output board_pkg::seg_t seg5,
    output board_pkg::seg_t seg6,
    output board_pkg::seg_t seg7,
    output board_pkg::led_t led
);

    import board_pkg::*;

    key_t   key_q;
    key_t   key_rise;
    count_t count;
    seg_t   digits [w_digit];

    assign key_rise = key & ~key_q;

    // Clear wins over decrement, decrement over increment, and the tick comes last
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            key_q <= '0;
            count <= '0;
        end
        else
        begin
            key_q <= key;
            if (key_rise[2])
                count <= '0;
            else if (key_rise[1])
                count <= count - 1'b1;    // Wraps below zero on purpose
            else if (key_rise[0])
                count <= count + 1'b1;
            else if (tick && key[3])
                count <= count + 1'b1;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Digit i shows nibble i of the count

    for (genvar i = 0; i < w_digit; i++)
    begin : g_digit
        assign digits[i] = hex_to_segments(count[4 * i +: 4]);
    end

    assign seg0 = digits[0];
    assign seg1 = digits[1];
    assign seg2 = digits[2];
    assign seg3 = digits[3];
    assign seg4 = digits[4];
    assign seg5 = digits[5];
    assign seg6 = digits[6];
    assign seg7 = digits[7];

    assign led  = count[7:0];

endmodule

// File: source/tm1638_link_arbiter.sv
`timescale 1ns/10ps

module tm1638_link_arbiter
# (
    parameter int sio_div = tm1638_pkg::sio_div_default
)
(
    input  logic              clk,
    input  logic              rst,

    input  logic              disp_req,
    input  logic              disp_rd,
    input  tm1638_pkg::byte_t disp_tx_byte,
    input  logic              disp_tx_last,
    output logic              disp_grant,
    output logic              disp_byte_done,
    output tm1638_pkg::byte_t disp_rx_byte,
    output logic              disp_rx_valid,

    input  logic              keys_req,
    input  logic              keys_rd,
    input  tm1638_pkg::byte_t keys_tx_byte,
    input  logic              keys_tx_last,
    output logic              keys_grant,
    output logic              keys_byte_done,
    output tm1638_pkg::byte_t keys_rx_byte,
    output logic              keys_rx_valid,

    output logic              sio_clk,
    output logic              sio_stb,
    output logic              sio_data_out,
    output logic              sio_data_oe,
    input  logic              sio_data_in
);

    import tm1638_pkg::*;

    localparam int w_div = $clog2(2 * sio_div);

    link_state_t        state;
    logic [w_div - 1:0] div_cnt;
    logic [2:0]         bit_cnt;
    logic               ph;            // Low or high half of sio_clk
    logic               owner;         // 0 for the display writer, 1 for the key reader
    logic               last_owner;
    logic               rd_flag, last_flag, end_flag;
    byte_t              sreg, rx_byte;

    logic               half_end, gap_end, bit_end, load, pick;
    logic               sel_req, sel_rd, sel_last;
    byte_t              sel_byte;

    assign half_end = div_cnt == w_div'(sio_div - 1);
    assign gap_end  = div_cnt == w_div'(2 * sio_div - 1);
    assign bit_end  = state == shift && ph && half_end;

    // A byte is taken after the strobe setup and after each byte that does not end a group
    assign load = (state == strobe_setup && half_end)
               || (bit_end && bit_cnt == 3'd7 && !last_flag);

    // The key reader wins when alone, or when the display writer went last
    assign pick = keys_req && (!disp_req || !last_owner);

    assign sel_req  = owner ? keys_req     : disp_req;
    assign sel_rd   = owner ? keys_rd      : disp_rd;
    assign sel_last = owner ? keys_tx_last : disp_tx_last;
    assign sel_byte = owner ? keys_tx_byte : disp_tx_byte;

    assign disp_byte_done = load && !owner;
    assign keys_byte_done = load &&  owner;
    assign disp_rx_byte   = rx_byte;
    assign keys_rx_byte   = rx_byte;

    assign sio_stb      = !(state == strobe_setup || state == shift);
    assign sio_clk      = !(state == shift && !ph);
    assign sio_data_out = (state == shift) ? sreg[0] : 1'b1;
    assign sio_data_oe  = !(state == shift && rd_flag);    // Chip drives data while reading

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Link FSM

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= idle;
            div_cnt       <= '0;
            bit_cnt       <= '0;
            ph            <= 1'b0;
            owner         <= 1'b0;
            last_owner    <= 1'b1;    // So the display goes first
            rd_flag       <= 1'b0;
            last_flag     <= 1'b0;
            end_flag      <= 1'b0;
            disp_grant    <= 1'b0;
            keys_grant    <= 1'b0;
            disp_rx_valid <= 1'b0;
            keys_rx_valid <= 1'b0;
        end
        else
        begin
            disp_grant    <= 1'b0;
            keys_grant    <= 1'b0;
            disp_rx_valid <= 1'b0;
            keys_rx_valid <= 1'b0;
            div_cnt       <= div_cnt + 1'b1;

            case (state)
                idle:
                begin
                    div_cnt <= '0;
                    if (disp_req || keys_req)
                    begin
                        owner      <= pick;
                        disp_grant <= !pick;
                        keys_grant <= pick;
                        state      <= strobe_setup;
                    end
                end
                strobe_setup:
                    if (half_end)
                    begin
                        div_cnt <= '0;
                        ph      <= 1'b0;    // First falling edge of sio_clk
                        bit_cnt <= '0;
                        state   <= shift;
                    end
                shift:
                    if (half_end)
                    begin
                        div_cnt <= '0;
                        ph      <= !ph;
                        if (ph)
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7)
                            begin
                                disp_rx_valid <= rd_flag && !owner;
                                keys_rx_valid <= rd_flag &&  owner;
                                if (last_flag)
                                    state <= gap;
                            end
                        end
                    end
                gap:
                    if (gap_end)
                    begin
                        div_cnt <= '0;
                        if (end_flag)
                        begin
                            state      <= idle;
                            last_owner <= owner;
                        end
                        else
                            state <= strobe_setup;    // Same owner, next group
                    end
                default:
                    state <= idle;
            endcase

            // A peer that has dropped req by its last byte ends the transaction
            if (load)
            begin
                rd_flag   <= sel_rd;
                last_flag <= sel_last;
                end_flag  <= !sel_req;
            end
        end
    end

    // One shift register for both directions: reads shift before the rising
    // edge, writes shift at the falling edge
    always_ff @(posedge clk)
    begin
        if (load)
            sreg <= sel_byte;
        else if (state == shift && half_end && (ph != rd_flag))
            sreg <= {rd_flag ? sio_data_in : 1'b0, sreg[7:1]};

        if (bit_end && bit_cnt == 3'd7)
            rx_byte <= sreg;
    end

    a_one_grant  : assert property (@(posedge clk) disable iff (rst)
        !(disp_grant && keys_grant));

    a_whole_byte : assert property (@(posedge clk) disable iff (rst)
        $rose(sio_stb) |-> $past(bit_end && bit_cnt == 3'd7));

endmodule

// File: source/tm1638_display_writer.sv
`timescale 1ns/10ps

module tm1638_display_writer
(
    input  logic              clk,
    input  logic              rst,

    input  board_pkg::seg_t   seg0,
    input  board_pkg::seg_t   seg1,
    input  board_pkg::seg_t   seg2,
    input  board_pkg::seg_t   seg3,
    input  board_pkg::seg_t   seg4,
    input  board_pkg::seg_t   seg5,
    input  board_pkg::seg_t   seg6,
    input  board_pkg::seg_t   seg7,
    input  board_pkg::led_t   led,

    output logic              req,
    output logic              rd,
    output tm1638_pkg::byte_t tx_byte,
    output logic              tx_last,
    input  logic              grant,
    input  logic              byte_done
);

    import board_pkg::*;
    import tm1638_pkg::*;

    // Mode command, address plus two bytes per digit, display control
    localparam int n_bytes = 2 * w_digit + 3;
    localparam int w_idx   = $clog2(n_bytes + 1);
    localparam int w_dsel  = $clog2(w_digit);

    logic               req_on;
    logic [w_idx - 1:0] idx;
    logic [w_idx - 1:0] data_idx;
    logic [w_dsel - 1:0] digit;
    logic               final_byte;
    seg_t               seg_in  [w_digit];
    seg_t               seg_img [w_digit];
    led_t               led_img;

    assign seg_in     = '{seg0, seg1, seg2, seg3, seg4, seg5, seg6, seg7};
    assign final_byte = idx == w_idx'(n_bytes - 1);
    assign req        = req_on && !(byte_done && final_byte);
    assign rd         = 1'b0;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte for the current index

    always_comb
    begin
        data_idx = idx - w_idx'(2);
        digit    = data_idx[w_dsel:1];
        tx_last  = idx == '0 || idx >= w_idx'(n_bytes - 2);    // Ends of the three groups

        if (idx == w_idx'(0))
            tx_byte = cmd_write_auto;
        else if (idx == w_idx'(1))
            tx_byte = cmd_addr_base;
        else if (idx >= w_idx'(n_bytes - 1))
            tx_byte = cmd_display_on;
        else if (data_idx[0])
            tx_byte = {7'd0, led_img[digit]};    // LED lives in bit 0 of the odd address
        else
            tx_byte = seg_img[digit];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            req_on <= 1'b0;
            idx    <= '0;
        end
        else
        begin
            req_on <= 1'b1;    // Refresh runs without pause
            if (grant)
                idx <= '0;
            else if (byte_done)
                idx <= idx + 1'b1;
        end
    end

    // One consistent image per frame
    always_ff @(posedge clk)
    begin
        if (grant)
        begin
            seg_img <= seg_in;
            led_img <= led;
        end
    end

endmodule

// File: source/tm1638_key_reader.sv
`timescale 1ns/10ps

module tm1638_key_reader
(
    input  logic              clk,
    input  logic              rst,

    output logic              req,
    output logic              rd,
    output tm1638_pkg::byte_t tx_byte,
    output logic              tx_last,
    input  logic              grant,
    input  logic              byte_done,
    input  tm1638_pkg::byte_t rx_byte,
    input  logic              rx_valid,

    output board_pkg::key_t   key
);

    import board_pkg::*;
    import tm1638_pkg::*;

    localparam int n_reads = 4;

    logic       req_on;
    logic       wait_rx;    // Last byte taken, read data still on the way
    logic [2:0] idx;
    logic [1:0] rd_cnt;
    key_t       key_acc;

    assign rd      = idx != 3'd0;
    assign tx_byte = (idx == 3'd0) ? cmd_read_keys : 8'hFF;
    assign tx_last = idx == 3'(n_reads);
    assign req     = req_on && !(byte_done && tx_last);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            req_on  <= 1'b0;
            wait_rx <= 1'b0;
            idx     <= '0;
            rd_cnt  <= '0;
            key     <= '0;
        end
        else
        begin
            if (byte_done && tx_last)
            begin
                req_on  <= 1'b0;
                wait_rx <= 1'b1;
            end
            else if (!wait_rx)
                req_on <= 1'b1;

            // All eight keys change together after the fourth byte
            if (rx_valid && rd_cnt == 2'd3)
            begin
                wait_rx <= 1'b0;
                key     <= {rx_byte[4], key_acc[6:4], rx_byte[0], key_acc[2:0]};
            end

            if (grant)
            begin
                idx    <= '0;
                rd_cnt <= '0;
            end
            else
            begin
                if (byte_done)
                    idx <= idx + 1'b1;
                if (rx_valid)
                    rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // Byte i holds key i in bit 0 and key i + 4 in bit 4
    always_ff @(posedge clk)
    begin
        if (rx_valid)
        begin
            key_acc[{1'b0, rd_cnt}] <= rx_byte[0];
            key_acc[{1'b1, rd_cnt}] <= rx_byte[4];
        end
    end

endmodule

// File: source/board_top.sv
`timescale 1ns/10ps

module board_top
# (
    parameter int clk_mhz = board_pkg::clk_mhz_default,
    parameter int tick_hz = board_pkg::tick_hz_default,
    parameter int sio_div = tm1638_pkg::sio_div_default
)
(
    input  logic              clk,
    input  logic              rst,

    output logic              sio_clk,
    output logic              sio_stb,
    output logic              sio_data_out,
    output logic              sio_data_oe,
    input  logic              sio_data_in,

    output board_pkg::led_t   led
);

    import board_pkg::*;
    import tm1638_pkg::*;

    logic  tick;
    key_t  key;
    seg_t  seg0, seg1, seg2, seg3, seg4, seg5, seg6, seg7;
    led_t  led_image;

    logic  disp_req, disp_rd, disp_tx_last, disp_grant, disp_byte_done;
    byte_t disp_tx_byte;

    logic  keys_req, keys_rd, keys_tx_last, keys_grant, keys_byte_done, keys_rx_valid;
    byte_t keys_tx_byte, keys_rx_byte;

    assign led = led_image;    // The board LEDs mirror what the panel shows

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lab side

    slow_tick_gen # (.fast_clk_mhz (clk_mhz), .tick_hz (tick_hz))
    i_slow_tick_gen (.*);

    lab_counter i_lab_counter (.led (led_image), .*);

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Panel side, two peers on one serial link

    tm1638_display_writer i_display_writer
    (
        .led       ( led_image      ),
        .req       ( disp_req       ),
        .rd        ( disp_rd        ),
        .tx_byte   ( disp_tx_byte   ),
        .tx_last   ( disp_tx_last   ),
        .grant     ( disp_grant     ),
        .byte_done ( disp_byte_done ),
        .*
    );

    tm1638_key_reader i_key_reader
    (
        .req       ( keys_req       ),
        .rd        ( keys_rd        ),
        .tx_byte   ( keys_tx_byte   ),
        .tx_last   ( keys_tx_last   ),
        .grant     ( keys_grant     ),
        .byte_done ( keys_byte_done ),
        .rx_byte   ( keys_rx_byte   ),
        .rx_valid  ( keys_rx_valid  ),
        .*
    );

    // The display writer never reads, so its receive side stays open
    tm1638_link_arbiter # (.sio_div (sio_div))
    i_link_arbiter
    (
        .disp_rx_byte  (  ),
        .disp_rx_valid (  ),
        .*
    );

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
# (
    parameter int period_ns = 8
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;    // First rising edge at half a period
    end

endmodule

// File: bench/board_top_tb.sv
`timescale 1ns/10ps

module board_top_tb;

    import board_pkg::*;
    import tm1638_pkg::*;

    localparam int clk_period_ns    = 8;
    localparam int frame_cycles_max = 1000;    // One frame and one key read take about 800

    logic   clk;
    logic   rst;
    logic   sio_clk, sio_stb, sio_data_out, sio_data_oe, sio_data_in;
    led_t   led;
    key_t   key_mask;

    key_t   step_mask [$];
    int     step_hold [$];
    count_t step_lo   [$];
    count_t step_hi   [$];
    logic   steps_loaded = 1'b0;
    int     errors       = 0;

    // TM1638 model state
    byte_t       rx_shift;
    byte_t       grp_first   = 8'h00;
    logic        in_group    = 1'b0;
    logic        reading     = 1'b0;
    logic [31:0] key_bits;
    int          bit_idx, grp_bytes, read_bits;
    int          key_groups  = 0;
    int          frames_done = 0;
    int          next_group  = 0;    // 0 mode command, 1 address group, 2 display control
    seg_t        shown_seg [w_digit];
    seg_t        frame_seg [w_digit];
    led_t        shown_led, frame_led;

    tb_clock_gen # (.period_ns (clk_period_ns)) i_clock_gen (.clk (clk));

    board_top # (.clk_mhz (1), .tick_hz (2000), .sio_div (2)) i_board_top (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic check_segments(input int digit, input seg_t got, input seg_t exp);
        if (got !== exp)
            report_error($sformatf("digit %0d shows %h, expected %h", digit, got, exp));
    endtask

    task automatic check_led(input string where, input led_t got, input led_t lo, input led_t hi);
        if ($isunknown(got) || got < lo || got > hi)
            report_error($sformatf("%s show %h, expected %h to %h", where, got, lo, hi));
    endtask

    // Byte i carries key i in bit 0 and key i + 4 in bit 4
    function automatic logic [31:0] pack_keys(input key_t mask);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < 4; i++)
        begin
            bits[8 * i]     = mask[i];
            bits[8 * i + 4] = mask[i + 4];
        end
        return bits;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // TM1638 model

    task automatic take_byte(input byte_t b);
        int data;
        if (grp_bytes == 0)
        begin
            grp_first = b;
            if (b == cmd_read_keys)
            begin
                key_groups++;
                key_bits = pack_keys(key_mask);
                reading  = 1'b1;
            end
            else if (b == cmd_write_auto)
            begin
                if (next_group != 0)
                    report_error("mode command in the middle of a display frame");
                if (key_groups != (frames_done > 0 ? 1 : 0))
                    report_error($sformatf("%0d key reads before frame %0d",
                                           key_groups, frames_done + 1));
                key_groups = 0;
                next_group = 1;
            end
            else if (b == cmd_addr_base)
            begin
                if (next_group != 1)
                    report_error("address command out of order");
                next_group = 2;
            end
            else if (b == cmd_display_on)
            begin
                if (next_group != 2)
                    report_error("display control command out of order");
                next_group = 0;
            end
            else
                report_error($sformatf("unknown command byte %h", b));
        end
        else if (grp_first == cmd_addr_base && grp_bytes <= 2 * w_digit)
        begin
            data = grp_bytes - 1;
            if (data % 2 == 0)
                shown_seg[data / 2] = b;
            else
                shown_led[data / 2] = b[0];
        end
        else
            report_error($sformatf("extra byte %h after command %h", b, grp_first));
        grp_bytes++;
    endtask

    task automatic end_group();
        if (grp_first == cmd_read_keys)
        begin
            if (read_bits != 32)
                report_error($sformatf("key read with %0d bits", read_bits));
        end
        else if (bit_idx != 0)
            report_error("strobe rose in the middle of a byte");
        else if (grp_first == cmd_addr_base && grp_bytes != 2 * w_digit + 1)
            report_error($sformatf("address group with %0d bytes", grp_bytes));
        else if (grp_first != cmd_addr_base && grp_bytes != 1)
            report_error($sformatf("command %h group with %0d bytes", grp_first, grp_bytes));

        if (grp_first == cmd_display_on)
        begin
            frame_seg = shown_seg;
            frame_led = shown_led;
            frames_done++;
        end
        reading = 1'b0;
    endtask

    always @(negedge sio_stb)
    begin
        in_group  = 1'b1;
        grp_first = 8'h00;
        bit_idx   = 0;
        grp_bytes = 0;
        read_bits = 0;
        reading   = 1'b0;
    end

    // The chip samples on the rising edge of sio_clk
    always @(posedge sio_clk)
    begin
        if (in_group && !sio_stb)
        begin
            // The data pin is released only while the chip returns key bytes
            if (sio_data_oe !== !reading)
                report_error($sformatf("data enable %b during a %s bit", sio_data_oe,
                                       reading ? "read" : "write"));
            if (reading)
                read_bits++;
            else
            begin
                rx_shift = {sio_data_out, rx_shift[7:1]};
                bit_idx++;
                if (bit_idx == 8)
                begin
                    bit_idx = 0;
                    take_byte(rx_shift);
                end
            end
        end
    end

    always @(posedge sio_stb)
    begin
        if (in_group)
        begin
            in_group = 1'b0;
            end_group();
        end
    end

    initial
    begin
        sio_data_in = 1'b1;
        forever
        begin
            @(negedge sio_clk);
            if (reading)
            begin
                #1;
                sio_data_in = key_bits[0];    // Key bits go out LSB first
                key_bits    = key_bits >> 1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus

    task automatic load_steps();
        int          fd;
        int          n;
        int          hold;
        string       line;
        logic [31:0] mask, lo, hi;
        fd = $fopen("bench/board_top_input.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the stimulus file bench/board_top_input.txt");
            $display("ERRORS FOUND");
            $fatal(1, "No stimulus");
        end
        while (!$feof(fd))
        begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#")
            begin
                if ($sscanf(line, "%h %d %h %h", mask, hold, lo, hi) == 4)
                begin
                    step_mask.push_back(mask[7:0]);
                    step_hold.push_back(hold);
                    step_lo.push_back(lo);
                    step_hi.push_back(hi);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        wait (frames_done >= target);
    endtask

    // Exact lines give lo equal to hi and range lines start from a cleared count
    task automatic check_frame(input count_t lo, input count_t hi);
        count_t shown;
        check_led("panel LEDs", frame_led, lo[7:0], hi[7:0]);
        check_led("board LEDs", led, lo[7:0], hi[7:0]);
        shown = (lo == hi) ? lo : {lo[31:8], frame_led};
        for (int i = 0; i < w_digit; i++)
            check_segments(i, frame_seg[i], hex_to_segments(shown[4 * i +: 4]));
    endtask

    initial
    begin
        rst      = 1'b1;
        key_mask = '0;
        load_steps();
        steps_loaded = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        if (sio_stb !== 1'b1 || sio_clk !== 1'b1 || sio_data_oe !== 1'b1)
            report_error("serial link not idle after reset");
        check_led("board LEDs", led, 8'h00, 8'h00);

        wait_frames(1);
        check_frame('0, '0);    // First frame shows all zeros

        foreach (step_mask[i])
        begin
            @(posedge clk);
            #1;
            key_mask = step_mask[i];
            wait_frames(step_hold[i]);
            @(posedge clk);
            #1;
            key_mask = '0;
            wait_frames(4);
            check_frame(step_lo[i], step_hi[i]);
        end

        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        longint limit_cycles;
        wait (steps_loaded);
        limit_cycles = 2 * frame_cycles_max;
        foreach (step_hold[i])
            limit_cycles += (step_hold[i] + 4) * frame_cycles_max;
        #(limit_cycles * clk_period_ns);
        $display("Timeout: no display frame completed in the time the test steps allow");
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: board_lab.f
source/board_pkg.sv
source/tm1638_pkg.sv
source/slow_tick_gen.sv
source/lab_counter.sv
source/tm1638_link_arbiter.sv
source/tm1638_display_writer.sv
source/tm1638_key_reader.sv
source/board_top.sv
bench/tb_clock_gen.sv
bench/board_top_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module board_top_tb -f board_lab.f

./obj_dir/Vboard_top_tb 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log
then
    echo "Simulation failed"
    exit 1
fi

if ! grep -q "NO ERRORS" sim.log
then
    echo "Simulation ended without a verdict"
    exit 1
fi

// File: bench/board_top_input.txt
# Columns: key mask (hex), hold in frames (decimal), lowest and highest count (hex)
# The count is read after the keys are released; lo equals hi for exact results
01 2 00000001 00000001
01 2 00000002 00000002
01 3 00000003 00000003
02 2 00000002 00000002
02 2 00000001 00000001
02 2 00000000 00000000
02 2 ffffffff ffffffff
01 2 00000000 00000000
01 2 00000001 00000001
01 2 00000002 00000002
04 2 00000000 00000000
01 2 00000001 00000001
05 2 00000000 00000000
01 2 00000001 00000001
01 2 00000002 00000002
05 3 00000000 00000000
08 4 00000002 0000000a
04 2 00000000 00000000
08 8 00000009 00000010
04 2 00000000 00000000
01 2 00000001 00000001
02 2 00000000 00000000
02 2 ffffffff ffffffff
04 2 00000000 00000000
01 2 00000001 00000001
